//--- src/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Returned on decode errors, easy to spot in a waveform
   localparam logic [DATA_W-1:0] ERR_RDATA = 32'hDEAD_BEEF;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } op_e;

   typedef enum logic [1:0] {
      TGT_LITE   = 2'd0,
      TGT_STREAM = 2'd1,
      TGT_NONE   = 2'd2
   } target_e;

   // Held native request, decoded
   typedef struct packed {
      op_e               op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } req_t;

   // Per-target completion
   typedef struct packed {
      logic              ready;
      logic              err;
      logic [DATA_W-1:0] rdata;
   } rsp_t;

endpackage

`default_nettype wire

//--- src/bus_decoder.sv
`default_nettype none

module bus_decoder
   import bridge_pkg::*;
#(
   parameter logic [ADDR_W-1:0] LITE_BASE   = 32'h0000_0000,
   parameter logic [ADDR_W-1:0] LITE_MASK   = 32'hF000_0000,
   parameter logic [ADDR_W-1:0] STREAM_BASE = 32'h1000_0000
) (
   input  wire logic              mem_valid,
   input  wire logic [ADDR_W-1:0] mem_addr,
   input  wire logic [DATA_W-1:0] mem_wdata,
   input  wire logic [STRB_W-1:0] mem_wstrb,
   output req_t                   req,
   output logic                   lite_sel,
   output logic                   stream_sel,
   output logic                   none_sel
);

   // Bit 2 selects data or status inside the stream window
   localparam logic [ADDR_W-1:0] STREAM_IGNORE = 32'h0000_0004;

   target_e target;
   logic    lite_hit;
   logic    stream_hit;

   always_comb begin
      req.op    = (|mem_wstrb) ? OP_WRITE : OP_READ;
      req.addr  = mem_addr;
      req.wdata = mem_wdata;
      req.wstrb = mem_wstrb;
   end

   assign lite_hit   = (mem_addr & LITE_MASK) == LITE_BASE;
   assign stream_hit = (mem_addr & ~STREAM_IGNORE) == STREAM_BASE;

   always_comb begin
      if (lite_hit) begin
         target = TGT_LITE;
      end else if (stream_hit && req.op == OP_READ) begin
         target = TGT_STREAM;
      end else begin
         // Unmapped, or a write to the read-only stream
         target = TGT_NONE;
      end
   end

   assign lite_sel   = mem_valid && (target == TGT_LITE);
   assign stream_sel = mem_valid && (target == TGT_STREAM);
   assign none_sel   = mem_valid && (target == TGT_NONE);

endmodule

`default_nettype wire

//--- src/native_axi_adapter.sv
`default_nettype none

module native_axi_adapter
   import bridge_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              resetn,
   input  wire logic              sel,
   input  wire req_t              req,
   output rsp_t                   rsp,

   output logic                   m_axi_awvalid,
   input  wire logic              m_axi_awready,
   output logic [ADDR_W-1:0]      m_axi_awaddr,

   output logic                   m_axi_wvalid,
   input  wire logic              m_axi_wready,
   output logic [DATA_W-1:0]      m_axi_wdata,
   output logic [STRB_W-1:0]      m_axi_wstrb,

   input  wire logic              m_axi_bvalid,
   output logic                   m_axi_bready,

   output logic                   m_axi_arvalid,
   input  wire logic              m_axi_arready,
   output logic [ADDR_W-1:0]      m_axi_araddr,

   input  wire logic              m_axi_rvalid,
   output logic                   m_axi_rready,
   input  wire logic [DATA_W-1:0] m_axi_rdata
);

   logic ack_awvalid;
   logic ack_arvalid;
   logic ack_wvalid;
   logic xfer_done;
   logic is_write;
   logic is_read;
   logic done_now;

   assign is_write = sel && (req.op == OP_WRITE);
   assign is_read  = sel && (req.op == OP_READ);

   // Each channel goes out once per request
   assign m_axi_awvalid = is_write && !ack_awvalid;
   assign m_axi_awaddr  = req.addr;

   assign m_axi_wvalid  = is_write && !ack_wvalid;
   assign m_axi_wdata   = req.wdata;
   assign m_axi_wstrb   = req.wstrb;

   assign m_axi_bready  = is_write;

   assign m_axi_arvalid = is_read && !ack_arvalid;
   assign m_axi_araddr  = req.addr;

   assign m_axi_rready  = is_read;

   assign done_now = (is_write && m_axi_bvalid) || (is_read && m_axi_rvalid);

   always_comb begin
      rsp.ready = done_now;
      rsp.err   = 1'b0;
      rsp.rdata = m_axi_rdata;
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ack_awvalid <= 1'b0;
         ack_arvalid <= 1'b0;
         ack_wvalid  <= 1'b0;
         xfer_done   <= 1'b0;
      end else begin
         xfer_done <= sel && done_now;
         if (m_axi_awvalid && m_axi_awready) begin
            ack_awvalid <= 1'b1;
         end
         if (m_axi_arvalid && m_axi_arready) begin
            ack_arvalid <= 1'b1;
         end
         if (m_axi_wvalid && m_axi_wready) begin
            ack_wvalid <= 1'b1;
         end
         // Request over, rearm for the next one
         if (xfer_done || !sel) begin
            ack_awvalid <= 1'b0;
            ack_arvalid <= 1'b0;
            ack_wvalid  <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/stream_read_port.sv
`default_nettype none

module stream_read_port
   import bridge_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              resetn,
   input  wire logic              sel,
   input  wire req_t              req,
   output rsp_t                   rsp,

   input  wire logic              s_axis_tvalid,
   output logic                   s_axis_tready,
   input  wire logic [DATA_W-1:0] s_axis_tdata
);

   logic        pop_sel;
   logic        status_sel;
   logic        status_rdy;
   logic        pop_fire;
   logic [15:0] pop_count;

   // Offset 0 pops, offset 4 reads status
   assign pop_sel    = sel && !req.addr[2];
   assign status_sel = sel && req.addr[2];

   assign s_axis_tready = pop_sel;
   assign pop_fire      = pop_sel && s_axis_tvalid;

   always_comb begin
      rsp.ready = pop_fire || (status_sel && status_rdy);
      rsp.err   = 1'b0;
      if (req.addr[2]) begin
         rsp.rdata = {pop_count, 15'd0, s_axis_tvalid};
      end else begin
         rsp.rdata = s_axis_tdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         status_rdy <= 1'b0;
         pop_count  <= '0;
      end else begin
         // One pulse per status read, then low until valid drops
         status_rdy <= status_sel && !status_rdy;
         if (pop_fire) begin
            pop_count <= pop_count + 16'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/response_merger.sv
`default_nettype none

module response_merger
   import bridge_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              resetn,
   input  wire logic              lite_sel,
   input  wire logic              stream_sel,
   input  wire logic              none_sel,
   input  wire rsp_t              lite_rsp,
   input  wire rsp_t              stream_rsp,
   output logic                   mem_ready,
   output logic                   mem_error,
   output logic [DATA_W-1:0]      mem_rdata
);

   logic err_rdy;
   rsp_t err_rsp;
   rsp_t out_rsp;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         err_rdy <= 1'b0;
      end else begin
         // Fires once, one cycle after an unmapped request shows up
         err_rdy <= none_sel && !err_rdy;
      end
   end

   always_comb begin
      err_rsp.ready = none_sel && err_rdy;
      err_rsp.err   = none_sel && err_rdy;
      err_rsp.rdata = ERR_RDATA;
   end

   always_comb begin
      if (lite_sel) begin
         out_rsp = lite_rsp;
      end else if (stream_sel) begin
         out_rsp = stream_rsp;
      end else if (none_sel) begin
         out_rsp = err_rsp;
      end else begin
         out_rsp = '0;
      end
   end

   assign mem_ready = out_rsp.ready;
   assign mem_error = out_rsp.ready && out_rsp.err;
   assign mem_rdata = out_rsp.rdata;

endmodule

`default_nettype wire

//--- src/native_bridge_top.sv
`default_nettype none

module native_bridge_top
   import bridge_pkg::*;
#(
   parameter logic [ADDR_W-1:0] LITE_BASE   = 32'h0000_0000,
   parameter logic [ADDR_W-1:0] LITE_MASK   = 32'hF000_0000,
   parameter logic [ADDR_W-1:0] STREAM_BASE = 32'h1000_0000
) (
   input  wire logic              clk,
   input  wire logic              resetn,

   input  wire logic              mem_valid,
   input  wire logic [ADDR_W-1:0] mem_addr,
   input  wire logic [DATA_W-1:0] mem_wdata,
   input  wire logic [STRB_W-1:0] mem_wstrb,
   output logic                   mem_ready,
   output logic [DATA_W-1:0]      mem_rdata,
   output logic                   mem_error,

   output logic                   m_axi_awvalid,
   input  wire logic              m_axi_awready,
   output logic [ADDR_W-1:0]      m_axi_awaddr,
   output logic                   m_axi_wvalid,
   input  wire logic              m_axi_wready,
   output logic [DATA_W-1:0]      m_axi_wdata,
   output logic [STRB_W-1:0]      m_axi_wstrb,
   input  wire logic              m_axi_bvalid,
   output logic                   m_axi_bready,
   output logic                   m_axi_arvalid,
   input  wire logic              m_axi_arready,
   output logic [ADDR_W-1:0]      m_axi_araddr,
   input  wire logic              m_axi_rvalid,
   output logic                   m_axi_rready,
   input  wire logic [DATA_W-1:0] m_axi_rdata,

   input  wire logic              s_axis_tvalid,
   output logic                   s_axis_tready,
   input  wire logic [DATA_W-1:0] s_axis_tdata
);

   req_t req;
   rsp_t lite_rsp;
   rsp_t stream_rsp;
   logic lite_sel;
   logic stream_sel;
   logic none_sel;

   bus_decoder #(
      .LITE_BASE   (LITE_BASE),
      .LITE_MASK   (LITE_MASK),
      .STREAM_BASE (STREAM_BASE)
   ) bus_decoder_i (
      .mem_valid  (mem_valid),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wstrb  (mem_wstrb),
      .req        (req),
      .lite_sel   (lite_sel),
      .stream_sel (stream_sel),
      .none_sel   (none_sel)
   );

   native_axi_adapter native_axi_adapter_i (
      .clk (clk), .resetn (resetn), .sel (lite_sel), .req (req), .rsp (lite_rsp),
      .m_axi_awvalid (m_axi_awvalid), .m_axi_awready (m_axi_awready),
      .m_axi_awaddr  (m_axi_awaddr),
      .m_axi_wvalid  (m_axi_wvalid),  .m_axi_wready  (m_axi_wready),
      .m_axi_wdata   (m_axi_wdata),   .m_axi_wstrb   (m_axi_wstrb),
      .m_axi_bvalid  (m_axi_bvalid),  .m_axi_bready  (m_axi_bready),
      .m_axi_arvalid (m_axi_arvalid), .m_axi_arready (m_axi_arready),
      .m_axi_araddr  (m_axi_araddr),
      .m_axi_rvalid  (m_axi_rvalid),  .m_axi_rready  (m_axi_rready),
      .m_axi_rdata   (m_axi_rdata)
   );

   stream_read_port stream_read_port_i (
      .clk (clk), .resetn (resetn), .sel (stream_sel), .req (req), .rsp (stream_rsp),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tdata  (s_axis_tdata)
   );

   response_merger response_merger_i (
      .clk (clk), .resetn (resetn),
      .lite_sel (lite_sel), .stream_sel (stream_sel), .none_sel (none_sel),
      .lite_rsp (lite_rsp), .stream_rsp (stream_rsp),
      .mem_ready (mem_ready), .mem_error (mem_error), .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

//--- tests/tb_native_bridge.sv
`default_nettype none

module tb_native_bridge
   import bridge_pkg::*;
();

   localparam logic [ADDR_W-1:0] LITE_BASE   = 32'h0000_0000;
   localparam logic [ADDR_W-1:0] LITE_MASK   = 32'hF000_0000;
   localparam logic [ADDR_W-1:0] STREAM_BASE = 32'h1000_0000;
   localparam logic [ADDR_W-1:0] STRB_ADDR   = 32'h0000_0300;
   localparam int                TIMEOUT     = 200;

   logic              clk = 1'b0;
   logic              resetn = 1'b0;
   logic              mem_valid = 1'b0;
   logic [ADDR_W-1:0] mem_addr = '0;
   logic [DATA_W-1:0] mem_wdata = '0;
   logic [STRB_W-1:0] mem_wstrb = '0;
   logic              mem_ready;
   logic [DATA_W-1:0] mem_rdata;
   logic              mem_error;
   logic              m_axi_awvalid;
   logic              m_axi_awready = 1'b0;
   logic [ADDR_W-1:0] m_axi_awaddr;
   logic              m_axi_wvalid;
   logic              m_axi_wready = 1'b0;
   logic [DATA_W-1:0] m_axi_wdata;
   logic [STRB_W-1:0] m_axi_wstrb;
   logic              m_axi_bvalid = 1'b0;
   logic              m_axi_bready;
   logic              m_axi_arvalid;
   logic              m_axi_arready = 1'b0;
   logic [ADDR_W-1:0] m_axi_araddr;
   logic              m_axi_rvalid = 1'b0;
   logic              m_axi_rready;
   logic [DATA_W-1:0] m_axi_rdata = '0;
   logic              s_axis_tvalid = 1'b0;
   logic              s_axis_tready;
   logic [DATA_W-1:0] s_axis_tdata = '0;

   // Memory model and stream source state
   logic [DATA_W-1:0] mem [0:255];
   logic [DATA_W-1:0] src_word [0:63];
   logic [5:0]        src_idx;
   logic [5:0]        shown_idx;
   logic              aw_seen;
   logic              w_seen;
   logic [ADDR_W-1:0] aw_addr;
   logic [DATA_W-1:0] w_data;
   logic [STRB_W-1:0] w_strb;
   logic              b_pending;
   logic              r_pending;
   logic [DATA_W-1:0] r_data;
   logic              stream_en = 1'b0;
   int                aw_count;
   int                w_count;
   int                ar_count;
   int                axis_count;
   logic [31:0]       stall_state = 32'd56731;

   // Test side state
   logic [31:0]       data_state = 32'd56731;
   int                aw_base;
   int                w_base;
   int                ar_base;
   int                axis_base;
   logic              done_tvalid;
   logic [15:0]       pop_total = '0;
   logic [5:0]        next_pop = '0;
   int                value_errors = 0;
   int                timeout_errors = 0;

   native_bridge_top #(
      .LITE_BASE   (LITE_BASE),
      .LITE_MASK   (LITE_MASK),
      .STREAM_BASE (STREAM_BASE)
   ) native_bridge_top_i (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
      return {a[15:0], a[31:16]} ^ ~a;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   function automatic rsp_t make_rsp(input logic ready, input logic err,
                                     input logic [DATA_W-1:0] rdata);
      rsp_t r;
      r.ready = ready;
      r.err   = err;
      r.rdata = rdata;
      return r;
   endfunction

   // Slave outputs change on the falling edge only
   always @(negedge clk) begin
      stall_state = xorshift(stall_state);
      if (!resetn) begin
         m_axi_awready = 1'b0;
         m_axi_wready  = 1'b0;
         m_axi_arready = 1'b0;
         m_axi_bvalid  = 1'b0;
         m_axi_rvalid  = 1'b0;
         s_axis_tvalid = 1'b0;
         shown_idx     = '0;
      end else begin
         m_axi_awready = stall_state[0];
         m_axi_wready  = stall_state[1];
         m_axi_arready = stall_state[2];
         m_axi_bvalid  = b_pending && stall_state[3];
         m_axi_rvalid  = r_pending && stall_state[4];
         m_axi_rdata   = r_data;
         // tvalid holds until the word is taken
         if (!s_axis_tvalid || src_idx != shown_idx) begin
            s_axis_tvalid = stream_en && (stall_state[6:5] != 2'b00);
         end
         shown_idx    = src_idx;
         s_axis_tdata = src_word[src_idx];
      end
   end

   always @(posedge clk) begin
      if (!resetn) begin
         for (int k = 0; k < 256; k++) begin
            mem[k] = fill_word(k * 4);
         end
         {aw_seen, w_seen, b_pending, r_pending} = '0;
         r_data = '0;
         src_idx = '0;
         {aw_count, w_count, ar_count, axis_count} = '0;
      end else begin
         if (m_axi_bvalid && m_axi_bready) begin
            b_pending = 1'b0;
         end
         if (m_axi_rvalid && m_axi_rready) begin
            r_pending = 1'b0;
         end
         if (m_axi_awvalid && m_axi_awready) begin
            aw_count++;
            aw_seen = 1'b1;
            aw_addr = m_axi_awaddr;
         end
         if (m_axi_wvalid && m_axi_wready) begin
            w_count++;
            w_seen = 1'b1;
            w_data = m_axi_wdata;
            w_strb = m_axi_wstrb;
         end
         if (m_axi_arvalid && m_axi_arready) begin
            ar_count++;
            r_pending = 1'b1;
            r_data = mem[m_axi_araddr[9:2]];
         end
         if (aw_seen && w_seen) begin
            mem[aw_addr[9:2]] = merge_bytes(mem[aw_addr[9:2]], w_data, w_strb);
            aw_seen = 1'b0;
            w_seen = 1'b0;
            b_pending = 1'b1;
         end
         if (s_axis_tvalid && s_axis_tready) begin
            axis_count++;
            src_idx++;
         end
      end
   end

   task automatic next_data(output logic [DATA_W-1:0] v);
      data_state = xorshift(data_state);
      v = data_state;
   endtask

   task automatic check_rsp(input string name, input rsp_t got, input rsp_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got ready=%0b err=%0b rdata=%h, expected ready=%0b err=%0b rdata=%h",
                  $time, name, got.ready, got.err, got.rdata, exp.ready, exp.err, exp.rdata);
         value_errors++;
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("FAIL %0t %s got %0d, expected %0d", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got %0b, expected %0b", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic start_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                               input logic [STRB_W-1:0] wstrb);
      @(negedge clk);
      aw_base   = aw_count;
      w_base    = w_count;
      ar_base   = ar_count;
      axis_base = axis_count;
      mem_valid = 1'b1;
      mem_addr  = addr;
      mem_wdata = wdata;
      mem_wstrb = wstrb;
   endtask

   // Latency counts the rising edges with mem_ready low
   task automatic wait_ready(output rsp_t got, output int latency);
      latency = 0;
      @(posedge clk);
      while (!mem_ready && latency < TIMEOUT) begin
         latency++;
         @(posedge clk);
      end
      if (!mem_ready) begin
         $display("Timeout: no mem_ready for address %h within %0d cycles", mem_addr, TIMEOUT);
         timeout_errors++;
      end
      done_tvalid = s_axis_tvalid;
      got = make_rsp(mem_ready, mem_error, mem_rdata);
   endtask

   task automatic end_access();
      @(negedge clk);
      mem_valid = 1'b0;
      mem_wstrb = '0;
   endtask

   task automatic access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                         input logic [STRB_W-1:0] wstrb, output rsp_t got, output int latency);
      start_access(addr, wdata, wstrb);
      wait_ready(got, latency);
      end_access();
   endtask

   task automatic check_handshakes(input int aw, input int w, input int ar, input int axis);
      check_count("m_axi_aw handshakes", aw_count - aw_base, aw);
      check_count("m_axi_w handshakes", w_count - w_base, w);
      check_count("m_axi_ar handshakes", ar_count - ar_base, ar);
      check_count("s_axis handshakes", axis_count - axis_base, axis);
   endtask

   task automatic reset_idle_levels();
      @(posedge clk);
      check_level("mem_ready", mem_ready, 1'b0);
      check_level("mem_error", mem_error, 1'b0);
      check_level("m_axi_awvalid", m_axi_awvalid, 1'b0);
      check_level("m_axi_wvalid", m_axi_wvalid, 1'b0);
      check_level("m_axi_arvalid", m_axi_arvalid, 1'b0);
      check_level("m_axi_bready", m_axi_bready, 1'b0);
      check_level("m_axi_rready", m_axi_rready, 1'b0);
      check_level("s_axis_tready", s_axis_tready, 1'b0);
   endtask

   task automatic lite_write_read();
      logic [ADDR_W-1:0] addr [0:7];
      logic [DATA_W-1:0] data [0:7];
      logic [DATA_W-1:0] rnd;
      rsp_t              got;
      int                latency;
      for (int i = 0; i < 8; i++) begin
         next_data(rnd);
         addr[i] = LITE_BASE + 32'h40 * 32'(i) + {28'd0, rnd[1:0], 2'b00};
         next_data(data[i]);
         access(addr[i], data[i], 4'hF, got, latency);
         check_level("mem_error", got.err, 1'b0);
         check_handshakes(1, 1, 0, 0);
      end
      for (int i = 0; i < 8; i++) begin
         access(addr[i], '0, '0, got, latency);
         check_rsp("lite read", got, make_rsp(1'b1, 1'b0, data[i]));
         check_handshakes(0, 0, 1, 0);
      end
   endtask

   task automatic partial_strobe_write();
      logic [STRB_W-1:0] strbs [0:2];
      logic [DATA_W-1:0] expected;
      logic [DATA_W-1:0] upd;
      rsp_t              got;
      int                latency;
      strbs[0] = 4'b0101;
      strbs[1] = 4'b1000;
      strbs[2] = 4'b0110;
      // Untouched word still holds its fill value
      expected = fill_word(STRB_ADDR);
      for (int i = 0; i < 3; i++) begin
         next_data(upd);
         access(STRB_ADDR, upd, strbs[i], got, latency);
         check_handshakes(1, 1, 0, 0);
         expected = merge_bytes(expected, upd, strbs[i]);
         access(STRB_ADDR, '0, '0, got, latency);
         check_rsp("strobe read", got, make_rsp(1'b1, 1'b0, expected));
      end
   endtask

   task automatic stream_stall_read();
      rsp_t got;
      int   latency;
      start_access(STREAM_BASE, '0, '0);
      repeat (3) begin
         @(posedge clk);
         check_level("mem_ready", mem_ready, 1'b0);
      end
      stream_en = 1'b1;
      wait_ready(got, latency);
      end_access();
      check_rsp("stream pop", got, make_rsp(1'b1, 1'b0, src_word[next_pop]));
      check_handshakes(0, 0, 0, 1);
      next_pop++;
      pop_total++;
   endtask

   task automatic pop_words(input int n);
      rsp_t got;
      int   latency;
      for (int i = 0; i < n; i++) begin
         access(STREAM_BASE, '0, '0, got, latency);
         check_rsp("stream pop", got, make_rsp(1'b1, 1'b0, src_word[next_pop]));
         check_handshakes(0, 0, 0, 1);
         next_pop++;
         pop_total++;
      end
   endtask

   task automatic status_read();
      rsp_t got;
      int   latency;
      access(STREAM_BASE + 32'h4, '0, '0, got, latency);
      check_rsp("stream status", got, make_rsp(1'b1, 1'b0, {pop_total, 15'd0, done_tvalid}));
      check_count("status latency", latency, 1);
      check_handshakes(0, 0, 0, 0);
   endtask

   task automatic error_responses();
      logic [ADDR_W-1:0] addrs [0:2];
      logic [STRB_W-1:0] strbs [0:2];
      logic [DATA_W-1:0] rnd;
      rsp_t              got;
      int                latency;
      addrs[0] = 32'h2000_0000;
      strbs[0] = 4'h0;
      addrs[1] = STREAM_BASE;
      strbs[1] = 4'hF;
      addrs[2] = STREAM_BASE + 32'h4;
      strbs[2] = 4'b0001;
      for (int i = 0; i < 3; i++) begin
         next_data(rnd);
         access(addrs[i], rnd, strbs[i], got, latency);
         check_rsp("error response", got, make_rsp(1'b1, 1'b1, ERR_RDATA));
         check_count("error latency", latency, 1);
         check_handshakes(0, 0, 0, 0);
      end
   endtask

   initial begin
      logic [DATA_W-1:0] word;
      for (int k = 0; k < 64; k++) begin
         next_data(word);
         src_word[k] = word;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;
      reset_idle_levels();
      lite_write_read();
      partial_strobe_write();
      stream_stall_read();
      pop_words(7);
      status_read();
      pop_words(5);
      status_read();
      error_responses();
      $display("Errors: %0d compare, %0d timeout", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
src/bridge_pkg.sv
src/bus_decoder.sv
src/native_axi_adapter.sv
src/stream_read_port.sv
src/response_merger.sv
src/native_bridge_top.sv
tests/tb_native_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_native_bridge
FILE_LIST ?= all.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing -j 0
SOURCES   := $(wildcard src/*.sv) $(wildcard tests/*.sv)
EXE       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass or fail comes from the log
run: compile
	./$(EXE) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
